// ==== core_pkg.sv ====
package core_pkg;

    // Datapath widths
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // 3R format, instruction bits 31..15
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_SLTU  = 17'h00025;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002A;
    localparam logic [16:0] OPC_XOR   = 17'h0002B;

    // 2RI12 format, instruction bits 31..22
    localparam logic [9:0] OPC_ADDI_W = 10'h00A;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // Decode stage record
    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   op;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        word_t     imm;
        logic      use_imm;
        logic      we;
    } dec_t;

    // Result heading to the register file
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      we;
        reg_addr_t rd;
        word_t     wdata;
    } wb_t;

endpackage

// ==== id_stage.sv ====
`timescale 1ns/100ps

module id_stage
    import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h1C00_0000
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  instr_valid_i,
    input  word_t instr_i,
    output dec_t  dec_o
);

    word_t pc_q;
    dec_t  dec_d;
    dec_t  dec_q;
    logic  known;

    always_comb begin
        dec_d       = '0;
        dec_d.valid = instr_valid_i;
        dec_d.pc    = pc_q;
        dec_d.rd    = instr_i[4:0];
        dec_d.rj    = instr_i[9:5];
        dec_d.rk    = instr_i[14:10];
        // si12 sits in bits 21..10
        dec_d.imm   = {{(XLEN-12){instr_i[21]}}, instr_i[21:10]};
        dec_d.op    = ALU_ADD;
        known       = 1'b1;

        if (instr_i[31:22] == OPC_ADDI_W) begin
            dec_d.use_imm = 1'b1;
        end else begin
            case (instr_i[31:15])
                OPC_ADD_W: dec_d.op = ALU_ADD;
                OPC_SUB_W: dec_d.op = ALU_SUB;
                OPC_SLT:   dec_d.op = ALU_SLT;
                OPC_SLTU:  dec_d.op = ALU_SLTU;
                OPC_AND:   dec_d.op = ALU_AND;
                OPC_OR:    dec_d.op = ALU_OR;
                OPC_XOR:   dec_d.op = ALU_XOR;
                default:   known = 1'b0;
            endcase
        end

        // Unknown encodings and r0 targets retire without a write
        dec_d.we = known && (dec_d.rd != '0);
    end

    // PC advances only on accepted instructions
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (instr_valid_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // Decode pipeline register, a bubble when no instruction arrives
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_d;
        end
    end

    assign dec_o = dec_q;

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps

module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    input  wb_t       wb_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o
);

    word_t regs [NUM_REGS];

    // Single write port from the commit stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.we) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    // Combinational reads, r0 is never written so it reads zero
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage
    import core_pkg::*;
(
    input  dec_t  dec_i,
    input  word_t rdata_a_i,
    input  word_t rdata_b_i,
    input  wb_t   wb_i,
    output wb_t   wb_o
);

    logic  fwd_a;
    logic  fwd_b;
    word_t src_a;
    word_t src_b;
    word_t opnd_b;
    word_t result;

    // Producer one cycle ahead still sits in the write-back register
    assign fwd_a = wb_i.valid && wb_i.we && (wb_i.rd == dec_i.rj);
    assign fwd_b = wb_i.valid && wb_i.we && (wb_i.rd == dec_i.rk);

    assign src_a  = fwd_a ? wb_i.wdata : rdata_a_i;
    assign src_b  = fwd_b ? wb_i.wdata : rdata_b_i;
    assign opnd_b = dec_i.use_imm ? dec_i.imm : src_b;

    always_comb begin
        case (dec_i.op)
            ALU_ADD:  result = src_a + opnd_b;
            ALU_SUB:  result = src_a - opnd_b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(opnd_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, src_a < opnd_b};
            ALU_AND:  result = src_a & opnd_b;
            ALU_OR:   result = src_a | opnd_b;
            ALU_XOR:  result = src_a ^ opnd_b;
            default:  result = '0;
        endcase
    end

    always_comb begin
        wb_o.valid = dec_i.valid;
        wb_o.pc    = dec_i.pc;
        wb_o.we    = dec_i.we;
        wb_o.rd    = dec_i.rd;
        wb_o.wdata = result;
    end

endmodule

// ==== commit_stage.sv ====
`timescale 1ns/100ps

module commit_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  wb_t        wb_i,
    output wb_t        wb_o,
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_addr_t  debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    wb_t wb_q;

    // Write-back register, feeds the register file and forwarding
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_i;
        end
    end

    assign wb_o = wb_q;

    // Trace registered on the same edge as the register file write
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            debug_wb_pc_o       <= '0;
            debug_wb_rf_wen_o   <= '0;
            debug_wb_rf_wnum_o  <= '0;
            debug_wb_rf_wdata_o <= '0;
        end else begin
            debug_wb_rf_wen_o <= {4{wb_q.valid && wb_q.we}};
            // Hold last retirement when idle
            if (wb_q.valid) begin
                debug_wb_pc_o       <= wb_q.pc;
                debug_wb_rf_wnum_o  <= wb_q.rd;
                debug_wb_rf_wdata_o <= wb_q.wdata;
            end
        end
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top
    import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h1C00_0000
) (
    input  logic       clk,
    input  logic       arst_n_i,

    input  logic       instr_valid_i,
    input  word_t      instr_i,

    // Registered commit trace
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_addr_t  debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    dec_t  id_ex;
    wb_t   ex_commit;
    wb_t   commit_wb;
    word_t rf_rdata_a;
    word_t rf_rdata_b;

    id_stage #(
        .RESET_PC(RESET_PC)
    ) u_id_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .dec_o        (id_ex)
    );

    // Operands are read while the instruction sits in the decode register
    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_a_i(id_ex.rj),
        .raddr_b_i(id_ex.rk),
        .wb_i     (commit_wb),
        .rdata_a_o(rf_rdata_a),
        .rdata_b_o(rf_rdata_b)
    );

    ex_stage u_ex_stage (
        .dec_i    (id_ex),
        .rdata_a_i(rf_rdata_a),
        .rdata_b_i(rf_rdata_b),
        .wb_i     (commit_wb),
        .wb_o     (ex_commit)
    );

    commit_stage u_commit_stage (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .wb_i               (ex_commit),
        .wb_o               (commit_wb),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

// ==== tb_cpu_top_assert.sv ====
`timescale 1ns/100ps

module cpu_top_assert (
    input logic       clk,
    input logic       arst_n_i,
    input logic       instr_valid_i,
    input logic [3:0] debug_wb_rf_wen_i
);

    // Write enable is a replicated single bit
    wen_uniform: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (debug_wb_rf_wen_i == 4'h0) || (debug_wb_rf_wen_i == 4'hF)
    ) else $error("debug write enable is neither all zeros nor all ones");

    // Nothing can retire right after reset
    wen_idle_after_reset: assert property (
        @(posedge clk) $rose(arst_n_i) |-> (debug_wb_rf_wen_i == 4'h0)
    ) else $error("debug write enable set in the first cycle after reset");

    // Trace register loads two edges after acceptance, seen one edge later here
    wen_needs_accept: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (debug_wb_rf_wen_i != 4'h0) |-> $past(instr_valid_i, 3)
    ) else $error("debug write enable without an accepted instruction");

endmodule

bind cpu_top cpu_top_assert u_cpu_top_assert (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .instr_valid_i    (instr_valid_i),
    .debug_wb_rf_wen_i(debug_wb_rf_wen_o)
);

// ==== tb_cpu_top.sv ====
`timescale 1ns/100ps

module tb_cpu_top;

    localparam logic [31:0] RESET_PC   = 32'h1C00_0000;
    localparam int          NUM_ROWS   = 24;
    localparam int          NUM_ROUNDS = 2;
    localparam int          TIMEOUT_NS = NUM_ROUNDS * NUM_ROWS * 5 * 20 + 1000;

    // LoongArch opcode fields
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002A;
    localparam logic [16:0] OP_XOR   = 17'h0002B;

    typedef struct packed {
        logic [31:0] instr;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] wdata;
    } row_t;

    // One pending retirement
    typedef struct packed {
        logic [31:0] pc;
        logic [7:0]  row;
        logic        round;
    } exp_t;

    logic        clk;
    logic        arst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_wen_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    row_t        tbl [NUM_ROWS];
    string       name_tbl [NUM_ROWS];
    exp_t        expect_q [$];
    logic [2:0]  accept_hist;
    logic [31:0] last_pc;
    logic        seen_retire;
    int          errors;
    int          accepted;
    int          gap;

    cpu_top #(
        .RESET_PC(RESET_PC)
    ) i_cpu_top (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .instr_valid_i      (instr_valid_i),
        .instr_i            (instr_i),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] enc_3r(input logic [16:0] opc, input int rd,
                                           input int rj, input int rk);
        return {opc, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_addi(input int rd, input int rj, input int si12);
        return {10'h00A, 12'(si12), 5'(rj), 5'(rd)};
    endfunction

    function automatic void set_row(input int idx, input string name, input logic [31:0] instr,
                                    input int we, input int rd, input logic [31:0] wdata);
        tbl[idx].instr = instr;
        tbl[idx].we    = (we != 0);
        tbl[idx].rd    = 5'(rd);
        tbl[idx].wdata = wdata;
        name_tbl[idx]  = name;
    endfunction

    // Every source register is written earlier in the table, so a second round repeats
    function automatic void fill_table();
        set_row(0,  "addi_pos",  enc_addi(1, 0, 5),              1, 1,  32'h0000_0005); // 5
        set_row(1,  "addi_neg",  enc_addi(2, 0, -3),             1, 2,  32'hFFFF_FFFD); // -3
        set_row(2,  "addi_max",  enc_addi(3, 0, 2047),           1, 3,  32'h0000_07FF); // 0x7FF
        set_row(3,  "addi_min",  enc_addi(4, 0, -2048),          1, 4,  32'hFFFF_F800); // -2048
        set_row(4,  "add",       enc_3r(OP_ADD_W, 5, 1, 3),      1, 5,  32'h0000_0804); // 5+0x7FF
        set_row(5,  "sub_fwd",   enc_3r(OP_SUB_W, 6, 5, 1),      1, 6,  32'h0000_07FF); // 0x804-5
        set_row(6,  "and_fwd",   enc_3r(OP_AND, 7, 6, 3),        1, 7,  32'h0000_07FF);
        set_row(7,  "or",        enc_3r(OP_OR, 8, 5, 2),         1, 8,  32'hFFFF_FFFD);
        set_row(8,  "xor_fwd",   enc_3r(OP_XOR, 9, 8, 1),        1, 9,  32'hFFFF_FFF8);
        set_row(9,  "slt_neg",   enc_3r(OP_SLT, 10, 2, 1),       1, 10, 32'h0000_0001); // -3 < 5
        set_row(10, "sltu_neg",  enc_3r(OP_SLTU, 11, 2, 1),      1, 11, 32'h0000_0000);
        set_row(11, "slt_pos",   enc_3r(OP_SLT, 12, 1, 2),       1, 12, 32'h0000_0000);
        set_row(12, "sltu_pos",  enc_3r(OP_SLTU, 13, 1, 2),      1, 13, 32'h0000_0001);
        set_row(13, "write_r0",  enc_addi(0, 1, 7),              0, 0,  32'h0000_000C); // no write
        set_row(14, "read_r0",   enc_3r(OP_ADD_W, 14, 0, 1),     1, 14, 32'h0000_0005); // 0+5
        set_row(15, "unknown",   32'hFFFF_FFFF,                  0, 31, 32'h0000_0000); // no write
        set_row(16, "sub_dist2", enc_3r(OP_SUB_W, 15, 14, 4),    1, 15, 32'h0000_0805); // 5+2048
        set_row(17, "and_neg",   enc_3r(OP_AND, 16, 9, 2),       1, 16, 32'hFFFF_FFF8);
        set_row(18, "addi_fwd",  enc_addi(17, 16, -8),           1, 17, 32'hFFFF_FFF0);
        set_row(19, "add_both",  enc_3r(OP_ADD_W, 18, 17, 17),   1, 18, 32'hFFFF_FFE0);
        set_row(20, "xor_neg",   enc_3r(OP_XOR, 19, 18, 4),      1, 19, 32'h0000_07E0);
        set_row(21, "slt_fwd",   enc_3r(OP_SLT, 20, 4, 19),      1, 20, 32'h0000_0001);
        set_row(22, "sltu_d2",   enc_3r(OP_SLTU, 21, 4, 19),     1, 21, 32'h0000_0000);
        set_row(23, "or_r0",     enc_3r(OP_OR, 22, 0, 3),        1, 22, 32'h0000_07FF);
    endfunction

    // Drives one row on the current edge and returns at the edge that accepts it
    task automatic drive_row(input int row, input int round);
        exp_t e;
        e.pc    = RESET_PC + 32'(4 * accepted);
        e.row   = 8'(row);
        e.round = 1'(round);
        expect_q.push_back(e);
        accepted++;
        instr_valid_i <= 1'b1;
        instr_i       <= tbl[row].instr;
        @(posedge clk);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            instr_valid_i <= 1'b0;
            instr_i       <= '0;
            @(posedge clk);
        end
    endtask

    task automatic check_retire(input exp_t e);
        row_t       r;
        string      tag;
        logic [3:0] exp_wen;
        r       = tbl[e.row];
        tag     = $sformatf("%s/round%0d", name_tbl[e.row], e.round);
        exp_wen = r.we ? 4'hF : 4'h0;
        if (debug_wb_pc_o != e.pc) begin
            $display("** Error %s pc: expected %h, actual %h", tag, e.pc, debug_wb_pc_o);
            errors++;
        end
        if (debug_wb_rf_wen_o != exp_wen) begin
            $display("** Error %s wen: expected %h, actual %h", tag, exp_wen, debug_wb_rf_wen_o);
            errors++;
        end
        if (r.we && debug_wb_rf_wnum_o != r.rd) begin
            $display("** Error %s wnum: expected %0d, actual %0d", tag, r.rd,
                     debug_wb_rf_wnum_o);
            errors++;
        end
        if (r.we && debug_wb_rf_wdata_o != r.wdata) begin
            $display("** Error %s wdata: expected %h, actual %h", tag, r.wdata,
                     debug_wb_rf_wdata_o);
            errors++;
        end
    endtask

    // Accept strobe history, bit 2 marks what the trace shows now
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            accept_hist <= '0;
        end else begin
            accept_hist <= {accept_hist[1:0], instr_valid_i};
        end
    end

    always @(negedge clk) begin
        if (arst_n_i) begin
            if (accept_hist[2]) begin
                check_retire(expect_q[0]);
                last_pc     = expect_q[0].pc;
                seen_retire = 1'b1;
                void'(expect_q.pop_front());
            end else begin
                if (debug_wb_rf_wen_o != 4'h0) begin
                    $display("** Error idle wen: expected 0, actual %h", debug_wb_rf_wen_o);
                    errors++;
                end
                if (seen_retire && debug_wb_pc_o != last_pc) begin
                    $display("** Error idle pc: expected %h, actual %h", last_pc, debug_wb_pc_o);
                    errors++;
                end
                if (!seen_retire && debug_wb_pc_o != 32'h0) begin
                    $display("** Error reset pc: expected 0, actual %h", debug_wb_pc_o);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("** Error: timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        errors        = 0;
        accepted      = 0;
        seen_retire   = 1'b0;
        last_pc       = '0;
        void'($urandom(32'h6ee3));
        fill_table();

        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);

        // First round back to back, second round with random idle gaps
        for (int round = 0; round < NUM_ROUNDS; round++) begin
            for (int row = 0; row < NUM_ROWS; row++) begin
                if (round == 1) begin
                    gap = $urandom_range(3, 0);
                    idle(gap);
                end
                drive_row(row, round);
            end
        end
        idle(6);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
core_pkg.sv
id_stage.sv
regfile.sv
ex_stage.sv
commit_stage.sv
cpu_top.sv
tb_cpu_top_assert.sv
tb_cpu_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu_top testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_cpu_top \
    -o sim_cpu_top

./obj_dir/sim_cpu_top > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a status line"
    exit 1
fi
echo "Simulation passed"
